// File: logic/font_rom.hex
// One glyph row per line as two hex digits, bit 7 is the leftmost pixel
// Four rows per glyph, glyphs in glyph enum order (0-F, @, W, R, E, space)
3C // 0
66
66
3C
18 // 1
38
18
3C
7C // 2
0C
30
7E
7C // 3
1C
0C
7C
6C // 4
6C
7E
0C
7E // 5
60
1E
7C
3C // 6
60
7E
3C
7E // 7
06
0C
18
3C // 8
3C
66
3C
3C // 9
7E
06
3C
3C // A
66
7E
66
7C // B
7C
66
7C
3E // C
60
60
3E
7C // D
66
66
7C
7E // E
78
60
7E
7E // F
60
78
60
3C // @
6E
6E
3E
63 // W
6B
7F
36
7C // R
66
7C
66
7E // E
78
60
7E
00 // space
00
00
00

// File: sdram_text.f
logic/memtest_pkg.sv
logic/text_pkg.sv
logic/mem_test_sequencer.sv
logic/text_screen_gen.sv
logic/font_raster.sv
logic/sdram_text_top.sv
testbench/tb_sdram_text_top.sv

// File: Bender.yml
package:
  name: sdram_text

sources:
  # Packages first, then the modules that import them
  - logic/memtest_pkg.sv
  - logic/text_pkg.sv
  - logic/mem_test_sequencer.sv
  - logic/text_screen_gen.sv
  - logic/font_raster.sv
  - logic/sdram_text_top.sv

  - target: test
    files:
      - testbench/tb_sdram_text_top.sv

// File: testbench/tb_sdram_text_top.sv
`default_nettype none

module tb_sdram_text_top;
    timeunit 1ns;
    timeprecision 100ps;

    import memtest_pkg::*;

    localparam int NUM_BURSTS     = 16;
    localparam int COLS           = 34;
    localparam int FRAME_PIX      = 4 * 4 * COLS * 8;
    localparam int NUM_FRAMES     = 22;   // Wraps once, reads burst 5 twice
    localparam int STARTUP_CYCLES = 256;
    localparam int WR_TIMEOUT     = 2000;
    localparam int FRM_TIMEOUT    = 30000;
    localparam logic [31:0]  SEED        = 32'h1a3a;
    localparam logic [127:0] EXP_PATTERN = 128'h0123456789ABCDEFFEDCBA9876543210;

    logic                  sys_clk;
    logic                  rst;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic                  mem_req_write;
    logic [ADDR_WIDTH-1:0] mem_req_addr;
    logic [DATA_WIDTH-1:0] mem_wr_data;
    logic                  mem_rd_valid;
    logic [DATA_WIDTH-1:0] mem_rd_data;
    logic                  pix_valid;
    logic                  pix_ready;
    logic                  pix_on;
    logic                  pix_last;
    logic                  error_free;
    logic                  write_phase;
    logic                  read_phase;
    logic                  display_phase;

    logic [127:0]          mem [NUM_BURSTS];
    logic [7:0]            font [84];
    logic [31:0]           mem_rng;
    logic [31:0]           sink_rng;
    int                    errs [1:5];
    int                    wr_count;
    int                    rd_count;
    int                    frames_done;
    int                    pix_idx;      // Position inside the current frame
    int                    bad_reads;
    logic                  hs_seen;      // Request accepted at the last rising edge
    logic                  hs_write;
    logic [ADDR_WIDTH-1:0] hs_addr;
    logic                  req_stall;
    logic                  held_write;
    logic [ADDR_WIDTH-1:0] held_addr;
    logic [DATA_WIDTH-1:0] held_data;
    logic                  rd_pending;
    int                    rd_wait;
    int                    rd_idx;
    logic [ADDR_WIDTH-1:0] rd_addr;
    int                    ready_wait;

    // One entry per read response, consumed at pix_last
    logic [ADDR_WIDTH-1:0] exp_addr_q [$];
    logic [127:0]          exp_data_q [$];
    int                    exp_err_q [$];

    sdram_text_top #(
        .MEM_BURSTS(NUM_BURSTS),
        .TEXT_COLS(COLS)
    ) dut_i (
        .sys_clk(sys_clk),
        .rst(rst),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_wr_data(mem_wr_data),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data(mem_rd_data),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_on(pix_on),
        .pix_last(pix_last),
        .error_free(error_free),
        .write_phase(write_phase),
        .read_phase(read_phase),
        .display_phase(display_phase)
    );

    always #2 sys_clk = ~sys_clk; // 4 ns period

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Digit pos of an ndig-digit hex value, leftmost first
    function automatic int hex_digit(input logic [127:0] v, input int ndig, input int pos);
        return int'(v[4 * (ndig - 1 - pos) +: 4]);
    endfunction

    function automatic int glyph_at(input int trow, input int col, input logic [22:0] addr,
                                    input logic [127:0] data, input int errors);
        int d;
        d = col - 2;
        if (col == 0)
            return 16 + trow; // Row labels @ W R E
        if (col == 1)
            return 20;
        case (trow)
            0:       return (d < 6) ? hex_digit(128'(addr), 6, d) : 20;
            1:       return (d < 32) ? hex_digit(EXP_PATTERN, 32, d) : 20;
            2:       return (d < 32) ? hex_digit(data, 32, d) : 20;
            default: return (d < 4) ? hex_digit(128'(errors), 4, d) : 20;
        endcase
    endfunction

    task automatic check(input bit cond, input int test, input string msg);
        assert (cond) else begin
            $display("Mismatch at %0t ns: %s", $time, msg);
            errs[test]++;
        end
    endtask

    task automatic report_test(input int test, input string name);
        if (errs[test] == 0)
            $display("Test %0d %s: ok", test, name);
        else
            $display("Test %0d %s: %0d errors", test, name, errs[test]);
    endtask

    task automatic wait_for_writes(output bit done);
        int cycles;
        cycles = 0;
        while (wr_count < NUM_BURSTS && cycles < WR_TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
        end
        done = (wr_count >= NUM_BURSTS);
        if (!done) begin
            $display("Timeout: the write pass did not finish within %0d cycles", WR_TIMEOUT);
            errs[2]++;
        end
    endtask

    task automatic wait_for_frame(input int count, output bit done);
        int cycles;
        cycles = 0;
        while (frames_done < count && cycles < FRM_TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
        end
        done = (frames_done >= count);
        if (!done) begin
            $display("Timeout: frame %0d did not complete within %0d cycles", count, FRM_TIMEOUT);
            errs[3]++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model and pixel sink, driven on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge sys_clk) begin
        if (rst) begin
            mem_req_ready <= 1'b0;
            mem_rd_valid  <= 1'b0;
            rd_pending = 1'b0;
            ready_wait = 0;
        end else begin
            mem_rd_valid <= 1'b0;
            if (rd_pending) begin
                if (rd_wait == 0) begin
                    mem_rd_valid <= 1'b1;
                    mem_rd_data  <= mem[rd_idx];
                    if (mem[rd_idx] != EXP_PATTERN)
                        bad_reads++;
                    exp_addr_q.push_back(rd_addr);
                    exp_data_q.push_back(mem[rd_idx]);
                    exp_err_q.push_back(bad_reads);
                    rd_pending = 1'b0;
                end else
                    rd_wait--;
            end
            if (hs_seen) begin
                mem_req_ready <= 1'b0; // Each request waits afresh
                mem_rng = lcg_step(mem_rng);
                ready_wait = int'(mem_rng[31:30]);
                if (!hs_write) begin
                    rd_pending = 1'b1;
                    rd_wait    = int'(mem_rng[29:27]);
                    rd_addr    = hs_addr;
                    rd_idx     = int'(hs_addr[6:3]);
                end
            end else if (mem_req_valid && !mem_req_ready) begin
                if (ready_wait == 0)
                    mem_req_ready <= 1'b1;
                else
                    ready_wait--;
            end
        end
    end

    always @(negedge sys_clk) begin
        if (rst)
            pix_ready <= 1'b0;
        else begin
            sink_rng = lcg_step(sink_rng);
            pix_ready <= (sink_rng[31:30] != 2'b00); // Stalls about one cycle in four
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshake monitor and checks at the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge sys_clk) begin
        logic exp_bit;
        int   total;
        int   trow;
        int   grow;
        int   col;
        int   px;
        int   g;
        if (rst) begin
            hs_seen <= 1'b0;
            req_stall = 1'b0;
        end else begin
            if (req_stall)
                check(mem_req_valid && mem_req_write == held_write &&
                      mem_req_addr == held_addr && mem_wr_data == held_data,
                      held_write ? 2 : 3, "request changed while waiting for ready");
            req_stall  = mem_req_valid && !mem_req_ready;
            held_write = mem_req_write;
            held_addr  = mem_req_addr;
            held_data  = mem_wr_data;
            hs_seen  <= mem_req_valid && mem_req_ready;
            hs_write <= mem_req_write;
            hs_addr  <= mem_req_addr;

            if (mem_req_valid && mem_req_ready && mem_req_write) begin
                check(wr_count < NUM_BURSTS && rd_count == 0, 2,
                      $sformatf("extra write to %0h", mem_req_addr));
                check(mem_req_addr == ADDR_WIDTH'(wr_count * 8), 2,
                      $sformatf("write address %0h, expected %0h", mem_req_addr, wr_count * 8));
                check(mem_wr_data == EXP_PATTERN, 2, $sformatf("write data %h", mem_wr_data));
                check(write_phase && !read_phase && !display_phase, 2,
                      $sformatf("phase flags %b%b%b during the write pass",
                                write_phase, read_phase, display_phase));
                mem[mem_req_addr[6:3]] = mem_wr_data;
                wr_count++;
            end

            if (mem_req_valid && mem_req_ready && !mem_req_write) begin
                total = frames_done * FRAME_PIX + pix_idx;
                check(wr_count == NUM_BURSTS, 3, "read issued before the write pass ended");
                check(mem_req_addr == ADDR_WIDTH'((rd_count % NUM_BURSTS) * 8), 3,
                      $sformatf("read address %0h, expected %0h", mem_req_addr,
                                (rd_count % NUM_BURSTS) * 8));
                check(read_phase && !write_phase && !display_phase, 3,
                      $sformatf("phase flags %b%b%b at read %0d",
                                write_phase, read_phase, display_phase, rd_count));
                check(total <= rd_count * FRAME_PIX && total + 2 >= rd_count * FRAME_PIX, 3,
                      $sformatf("%0d pixels delivered before read %0d", total, rd_count));
                check(error_free === (bad_reads == 0), 5,
                      $sformatf("error_free %b before read %0d", error_free, rd_count));
                rd_count++;
            end

            if (pix_valid && pix_ready) begin
                if (exp_addr_q.size() == 0) begin
                    $display("Pixel at %0t ns arrived while no frame was expected", $time);
                    errs[3]++;
                end else begin
                    px   = pix_idx % 8;
                    col  = (pix_idx / 8) % COLS;
                    grow = (pix_idx / (8 * COLS)) % 4;
                    trow = pix_idx / (8 * COLS * 4);
                    g    = glyph_at(trow, col, exp_addr_q[0], exp_data_q[0], exp_err_q[0]);
                    exp_bit = font[g * 4 + grow][7 - px];
                    check(pix_on === exp_bit, (trow == 3) ? 5 : 4,
                          $sformatf("frame %0d row %0d.%0d col %0d px %0d is %b, expected %b",
                                    frames_done, trow, grow, col, px, pix_on, exp_bit));
                    // Only the last two pixels may trail the display phase
                    if (pix_idx < FRAME_PIX - 2)
                        check(display_phase && !read_phase && !write_phase, 3,
                              $sformatf("display_phase %b read_phase %b at pixel %0d",
                                        display_phase, read_phase, pix_idx));
                    check(pix_last === (pix_idx == FRAME_PIX - 1), 3,
                          $sformatf("pix_last %b at pixel %0d of frame %0d",
                                    pix_last, pix_idx, frames_done));
                    if (pix_last || pix_idx == FRAME_PIX - 1) begin
                        void'(exp_addr_q.pop_front());
                        void'(exp_data_q.pop_front());
                        void'(exp_err_q.pop_front());
                        pix_idx = 0;
                        frames_done++;
                    end else
                        pix_idx++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        bit ok;
        int i;
        int f;
        int total_errs;
        int passed;
        rst           = 1'b1;
        sys_clk       = 1'b0;
        mem_req_ready = 1'b0;
        mem_rd_valid  = 1'b0;
        mem_rd_data   = '0;
        pix_ready     = 1'b0;
        mem_rng       = SEED;
        sink_rng      = lcg_step(SEED);
        wr_count      = 0;
        rd_count      = 0;
        frames_done   = 0;
        pix_idx       = 0;
        bad_reads     = 0;
        for (i = 1; i <= 5; i++)
            errs[i] = 0;
        $readmemh("logic/font_rom.hex", font);

        repeat (4) @(negedge sys_clk);
        check(!mem_req_valid && !pix_valid && !write_phase && !read_phase && !display_phase &&
              error_free, 1, "outputs not idle during reset");
        repeat (12) @(negedge sys_clk);
        rst = 1'b0;
        for (i = 1; i < STARTUP_CYCLES; i++) begin
            @(negedge sys_clk);
            check(!mem_req_valid && !pix_valid && error_free && write_phase && !read_phase &&
                  !display_phase, 1, $sformatf("activity in start-up cycle %0d", i));
        end
        report_test(1, "start-up idle");

        wait_for_writes(ok);
        report_test(2, "write pass");
        if (ok) begin
            mem[5][15:0] = ~mem[5][15:0]; // Burst 5 fails its compare from now on
            for (f = 1; f <= NUM_FRAMES && ok; f++)
                wait_for_frame(f, ok);
        end
        if (ok)
            check(!error_free, 5, "error_free still high after burst 5 was read");
        report_test(3, "read order and framing");
        report_test(4, "pixel content");
        report_test(5, "error counting");

        total_errs = 0;
        passed     = 0;
        for (i = 1; i <= 5; i++) begin
            total_errs += errs[i];
            if (errs[i] == 0)
                passed++;
        end
        $display("Summary: 5 tests, %0d passed, %0d failed, %0d errors",
                 passed, 5 - passed, total_errs);
        if (ok && total_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sdram_text_top.sv
`default_nettype none

module sdram_text_top #(
    parameter int MEM_BURSTS = 1048576,
    parameter int TEXT_COLS  = 40
) (
    input  logic                               sys_clk,
    input  logic                               rst,
    output logic                               mem_req_valid,
    input  logic                               mem_req_ready,
    output logic                               mem_req_write,
    output logic [memtest_pkg::ADDR_WIDTH-1:0] mem_req_addr,
    output logic [memtest_pkg::DATA_WIDTH-1:0] mem_wr_data,
    input  logic                               mem_rd_valid,
    input  logic [memtest_pkg::DATA_WIDTH-1:0] mem_rd_data,
    output logic                               pix_valid,
    input  logic                               pix_ready,
    output logic                               pix_on,
    output logic                               pix_last,
    output logic                               error_free,
    output logic                               write_phase,
    output logic                               read_phase,
    output logic                               display_phase
);
    import memtest_pkg::*;
    import text_pkg::*;

    logic                          frame_start;
    logic                          frame_done;
    logic [ADDR_WIDTH-1:0]         shown_addr;
    logic [DATA_WIDTH-1:0]         shown_data;
    logic [ERR_WIDTH-1:0]          error_count;
    logic                          glyph_valid;
    logic                          glyph_ready;
    glyph_e                        glyph;
    logic [$clog2(GLYPH_ROWS)-1:0] glyph_row;
    logic [$clog2(GLYPH_W_PX)-1:0] glyph_col_px;
    logic                          frame_end;

    mem_test_sequencer #(
        .MEM_BURSTS(MEM_BURSTS)
    ) sequencer_i (
        .sys_clk(sys_clk),
        .rst(rst),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_wr_data(mem_wr_data),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data(mem_rd_data),
        .frame_start(frame_start),
        .frame_done(frame_done),
        .shown_addr(shown_addr),
        .shown_data(shown_data),
        .error_count(error_count),
        .write_phase(write_phase),
        .read_phase(read_phase),
        .display_phase(display_phase),
        .error_free(error_free)
    );

    text_screen_gen #(
        .TEXT_COLS(TEXT_COLS)
    ) screen_gen_i (
        .sys_clk(sys_clk),
        .rst(rst),
        .frame_start(frame_start),
        .frame_done(frame_done),
        .shown_addr(shown_addr),
        .shown_data(shown_data),
        .error_count(error_count),
        .glyph_valid(glyph_valid),
        .glyph_ready(glyph_ready),
        .glyph(glyph),
        .glyph_row(glyph_row),
        .glyph_col_px(glyph_col_px),
        .frame_end(frame_end)
    );

    font_raster raster_i (
        .sys_clk(sys_clk),
        .rst(rst),
        .glyph_valid(glyph_valid),
        .glyph_ready(glyph_ready),
        .glyph(glyph),
        .glyph_row(glyph_row),
        .glyph_col_px(glyph_col_px),
        .frame_end(frame_end),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_on(pix_on),
        .pix_last(pix_last)
    );

endmodule

`default_nettype wire

// File: logic/font_raster.sv
`default_nettype none

module font_raster (
    input  logic                                     sys_clk,
    input  logic                                     rst,
    input  logic                                     glyph_valid,
    output logic                                     glyph_ready,
    input  text_pkg::glyph_e                         glyph,
    input  logic [$clog2(text_pkg::GLYPH_ROWS)-1:0]  glyph_row,
    input  logic [$clog2(text_pkg::GLYPH_W_PX)-1:0]  glyph_col_px,
    input  logic                                     frame_end,
    output logic                                     pix_valid,
    input  logic                                     pix_ready,
    output logic                                     pix_on,
    output logic                                     pix_last
);
    import text_pkg::*;

    localparam int ROM_AW = $clog2(FONT_DEPTH);
    localparam int PX_W   = $clog2(GLYPH_W_PX);

    logic [GLYPH_W_PX-1:0] font_rom [FONT_DEPTH];

    logic                  s1_valid;
    logic [GLYPH_W_PX-1:0] s1_bits;  // Registered ROM word
    logic [PX_W-1:0]       s1_col;
    logic                  s1_last;
    logic                  s1_en;
    logic                  s2_en;
    logic [ROM_AW-1:0]     rom_idx;

    initial $readmemh("logic/font_rom.hex", font_rom);

    assign rom_idx     = ROM_AW'(glyph) * ROM_AW'(GLYPH_ROWS) + ROM_AW'(glyph_row);
    assign s2_en       = !pix_valid || pix_ready;
    assign s1_en       = !s1_valid || s2_en; // Stage 1 moves when stage 2 has room
    assign glyph_ready = s1_en;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            if (s1_en)
                s1_valid <= glyph_valid;
            if (s2_en)
                pix_valid <= s1_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (s1_en && glyph_valid) begin
            s1_bits <= font_rom[rom_idx];
            s1_col  <= glyph_col_px;
            s1_last <= frame_end;
        end
        if (s2_en && s1_valid) begin
            pix_on   <= s1_bits[s1_col]; // Bit 7 is the leftmost pixel
            pix_last <= s1_last;
        end
    end

    // Upstream keeps its glyph steady until this stage takes it
    glyph_held_while_stalled: assert property (@(posedge sys_clk) disable iff (rst)
        glyph_valid && !glyph_ready |=> glyph_valid && $stable(glyph) &&
            $stable(glyph_row) && $stable(glyph_col_px) && $stable(frame_end));

endmodule

`default_nettype wire

// File: logic/text_screen_gen.sv
`default_nettype none

module text_screen_gen #(
    parameter int TEXT_COLS = 40
) (
    input  logic                                     sys_clk,
    input  logic                                     rst,
    input  logic                                     frame_start,
    output logic                                     frame_done,
    input  logic [memtest_pkg::ADDR_WIDTH-1:0]       shown_addr,
    input  logic [memtest_pkg::DATA_WIDTH-1:0]       shown_data,
    input  logic [memtest_pkg::ERR_WIDTH-1:0]        error_count,
    output logic                                     glyph_valid,
    input  logic                                     glyph_ready,
    output text_pkg::glyph_e                         glyph,
    output logic [$clog2(text_pkg::GLYPH_ROWS)-1:0]  glyph_row,
    output logic [$clog2(text_pkg::GLYPH_W_PX)-1:0]  glyph_col_px,
    output logic                                     frame_end
);
    import memtest_pkg::*;
    import text_pkg::*;

    localparam int COL_W       = $clog2(TEXT_COLS);
    localparam int TROW_W      = $clog2(TEXT_ROWS);
    localparam int GROW_W      = $clog2(GLYPH_ROWS);
    localparam int PX_W        = $clog2(GLYPH_W_PX);
    localparam int ADDR_DIGITS = 6; // Address shown as 24 bits
    localparam int DATA_DIGITS = DATA_WIDTH / 4;
    localparam int ERR_DIGITS  = ERR_WIDTH / 4;

    logic [COL_W-1:0]  col;
    logic [TROW_W-1:0] text_row;
    logic [COL_W-1:0]  dig;      // Digit index, valid from column 2
    logic              step;
    logic              last_px;
    logic              last_col;
    logic              last_grow;
    logic              last_trow;

    // Nibble idx of an ndig-digit value, most significant first
    function automatic glyph_e hex_glyph(input logic [DATA_WIDTH-1:0] value,
                                         input int unsigned ndig,
                                         input int unsigned idx);
        logic [DATA_WIDTH-1:0] shifted;
        shifted = value >> (4 * (ndig - 1 - idx));
        return glyph_e'(5'(shifted[3:0]));
    endfunction

    assign step      = glyph_valid && glyph_ready;
    assign last_px   = (glyph_col_px == '0);
    assign last_col  = (col == COL_W'(TEXT_COLS - 1));
    assign last_grow = (glyph_row == GROW_W'(GLYPH_ROWS - 1));
    assign last_trow = (text_row == TROW_W'(TEXT_ROWS - 1));
    assign frame_end = last_px && last_col && last_grow && last_trow;

    ////////////////////////////////////////////////////////////
    // Position counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            glyph_valid  <= 1'b0;
            frame_done   <= 1'b0;
            glyph_col_px <= PX_W'(GLYPH_W_PX - 1);
            col          <= '0;
            glyph_row    <= '0;
            text_row     <= '0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                glyph_valid  <= 1'b1;
                glyph_col_px <= PX_W'(GLYPH_W_PX - 1);
                col          <= '0;
                glyph_row    <= '0;
                text_row     <= '0;
            end else if (step) begin
                glyph_col_px <= last_px ? PX_W'(GLYPH_W_PX - 1) : glyph_col_px - 1'b1;
                if (last_px)
                    col <= last_col ? '0 : col + 1'b1;
                if (last_px && last_col)
                    glyph_row <= last_grow ? '0 : glyph_row + 1'b1;
                if (last_px && last_col && last_grow)
                    text_row <= last_trow ? '0 : text_row + 1'b1;
                if (frame_end) begin
                    glyph_valid <= 1'b0; // Frame complete
                    frame_done  <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Glyph choice per character slot
    ////////////////////////////////////////////////////////////

    always_comb begin
        dig   = col - COL_W'(2);
        glyph = GLYPH_SPACE;
        if (col == '0) begin
            case (text_row)
                0:       glyph = GLYPH_AT;
                1:       glyph = GLYPH_W;
                2:       glyph = GLYPH_R;
                default: glyph = GLYPH_E;
            endcase
        end else if (col >= COL_W'(2)) begin
            case (text_row)
                0: if (int'(dig) < ADDR_DIGITS)
                    glyph = hex_glyph(DATA_WIDTH'(shown_addr), ADDR_DIGITS, dig);
                1: if (int'(dig) < DATA_DIGITS)
                    glyph = hex_glyph(TEST_PATTERN, DATA_DIGITS, dig);
                2: if (int'(dig) < DATA_DIGITS)
                    glyph = hex_glyph(shown_data, DATA_DIGITS, dig);
                default: if (int'(dig) < ERR_DIGITS)
                    glyph = hex_glyph(DATA_WIDTH'(error_count), ERR_DIGITS, dig);
            endcase
        end
    end

    // Glyphs only flow between frame_start and frame_done
    no_glyph_outside_frame: assert property (@(posedge sys_clk) disable iff (rst)
        !glyph_valid && !frame_start |=> !glyph_valid);

    // Displayed values must not move under a frame in progress
    shown_held_during_frame: assert property (@(posedge sys_clk) disable iff (rst)
        glyph_valid |=> $stable(shown_addr) && $stable(shown_data) && $stable(error_count));

endmodule

`default_nettype wire

// File: logic/mem_test_sequencer.sv
`default_nettype none

module mem_test_sequencer #(
    parameter int MEM_BURSTS = 1048576
) (
    input  logic                               sys_clk,
    input  logic                               rst,
    output logic                               mem_req_valid,
    input  logic                               mem_req_ready,
    output logic                               mem_req_write,
    output logic [memtest_pkg::ADDR_WIDTH-1:0] mem_req_addr,
    output logic [memtest_pkg::DATA_WIDTH-1:0] mem_wr_data,
    input  logic                               mem_rd_valid,
    input  logic [memtest_pkg::DATA_WIDTH-1:0] mem_rd_data,
    output logic                               frame_start,
    input  logic                               frame_done,
    output logic [memtest_pkg::ADDR_WIDTH-1:0] shown_addr,
    output logic [memtest_pkg::DATA_WIDTH-1:0] shown_data,
    output logic [memtest_pkg::ERR_WIDTH-1:0]  error_count,
    output logic                               write_phase,
    output logic                               read_phase,
    output logic                               display_phase,
    output logic                               error_free
);
    import memtest_pkg::*;

    localparam int BIDX_W  = (MEM_BURSTS > 1) ? $clog2(MEM_BURSTS) : 1;
    localparam int DELAY_W = $clog2(START_DELAY);

    seq_state_e                state;
    seq_state_e                state_next;
    logic [DELAY_W-1:0]        delay_cnt;
    logic [BIDX_W-1:0]         burst_idx;
    logic                      last_burst;
    logic [DATA_WIDTH-1:0]     rd_buf;     // Response held until CHECK

    assign last_burst    = (burst_idx == BIDX_W'(MEM_BURSTS - 1));
    assign mem_req_valid = (state == WR_REQ) || (state == RD_REQ);
    assign mem_req_write = (state == WR_REQ);
    assign mem_req_addr  = ADDR_WIDTH'(burst_idx) * ADDR_WIDTH'(BURST_LEN);
    assign mem_wr_data   = TEST_PATTERN; // Same pattern in every burst
    assign error_free    = (error_count == '0);

    always_comb begin
        state_next = state;
        case (state)
            INIT:    if (delay_cnt == DELAY_W'(START_DELAY - 1)) state_next = WR_REQ;
            WR_REQ:  if (mem_req_ready && last_burst) state_next = RD_REQ;
            RD_REQ:  if (mem_req_ready) state_next = RD_WAIT;
            RD_WAIT: if (mem_rd_valid) state_next = CHECK;
            CHECK:   state_next = DISPLAY;
            DISPLAY: if (frame_done) state_next = RD_REQ;
            default: state_next = INIT;
        endcase
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state         <= INIT;
            delay_cnt     <= '0;
            burst_idx     <= '0;
            error_count   <= '0;
            frame_start   <= 1'b0;
            write_phase   <= 1'b0;
            read_phase    <= 1'b0;
            display_phase <= 1'b0;
        end else begin
            state       <= state_next;
            frame_start <= (state == CHECK); // First DISPLAY cycle

            if (state == INIT)
                delay_cnt <= delay_cnt + 1'b1;

            // Step to the next burst after a write, or once a frame is shown
            if ((state == WR_REQ && mem_req_ready) || (state == DISPLAY && frame_done)) begin
                burst_idx <= last_burst ? '0 : burst_idx + 1'b1;
            end

            if (state == CHECK && rd_buf != TEST_PATTERN && error_count != '1)
                error_count <= error_count + 1'b1; // Saturating

            // Flags follow the state being entered
            write_phase   <= (state_next == INIT) || (state_next == WR_REQ);
            read_phase    <= (state_next == RD_REQ) || (state_next == RD_WAIT) ||
                             (state_next == CHECK);
            display_phase <= (state_next == DISPLAY);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == RD_WAIT && mem_rd_valid)
            rd_buf <= mem_rd_data;
        if (state == CHECK) begin
            shown_data <= rd_buf;
            shown_addr <= mem_req_addr; // Index only moves on frame_done
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    req_held_until_ready: assert property (@(posedge sys_clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
            $stable(mem_req_addr) && $stable(mem_wr_data));

    rd_resp_only_when_waiting: assert property (@(posedge sys_clk) disable iff (rst)
        mem_rd_valid |-> state == RD_WAIT);

endmodule

`default_nettype wire

// File: logic/text_pkg.sv
`default_nettype none

package text_pkg;

    // Hex digits first so a nibble maps straight onto its glyph code
    typedef enum logic [4:0] {
        GLYPH_HEX_0, GLYPH_HEX_1, GLYPH_HEX_2, GLYPH_HEX_3,
        GLYPH_HEX_4, GLYPH_HEX_5, GLYPH_HEX_6, GLYPH_HEX_7,
        GLYPH_HEX_8, GLYPH_HEX_9, GLYPH_HEX_A, GLYPH_HEX_B,
        GLYPH_HEX_C, GLYPH_HEX_D, GLYPH_HEX_E, GLYPH_HEX_F,
        GLYPH_AT    = 5'd16,
        GLYPH_W     = 5'd17,
        GLYPH_R     = 5'd18,
        GLYPH_E     = 5'd19,
        GLYPH_SPACE = 5'd20
    } glyph_e;

    localparam int GLYPH_W_PX = 8;  // Pixels per glyph row
    localparam int GLYPH_ROWS = 4;  // Rows per glyph
    localparam int TEXT_ROWS  = 4;  // Lines on the screen
    localparam int FONT_DEPTH = 84; // 21 glyphs x 4 rows

endpackage

`default_nettype wire

// File: logic/memtest_pkg.sv
`default_nettype none

package memtest_pkg;

    ////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 23;  // Word address
    localparam int BURST_LEN  = 8;   // 16-bit words per burst
    localparam int DATA_WIDTH = 128; // One full burst

    ////////////////////////////////////////////////////////////
    // Test settings
    ////////////////////////////////////////////////////////////

    localparam logic [DATA_WIDTH-1:0] TEST_PATTERN = 128'h0123456789ABCDEFFEDCBA9876543210;
    localparam int ERR_WIDTH   = 16;
    localparam int START_DELAY = 256; // Cycles spent in INIT

    typedef enum logic [2:0] {
        INIT,
        WR_REQ,
        RD_REQ,
        RD_WAIT,
        CHECK,
        DISPLAY
    } seq_state_e;

endpackage

`default_nettype wire
